//--- src/otp_part_pkg.sv
/*
  Shared widths, fixed partition geometry and codes of the unbuffered OTP partition.
  The partition must stay 8-byte aligned and below the 2 KiB macro byte space.
*/
`default_nettype none

package otp_part_pkg;

  ////////////////////////////////////////////////////
  // Macro and bus widths
  ////////////////////////////////////////////////////

  // One macro word is a 16 bit halfword
  localparam int unsigned OtpWidth         = 16;
  localparam int unsigned OtpAddrShift     = 1;
  localparam int unsigned OtpByteAddrWidth = 11;
  localparam int unsigned OtpAddrWidth     = 10;
  // Size field counts macro words minus one
  localparam int unsigned OtpSizeWidth     = 2;
  localparam int unsigned BlockWidth       = 64;
  // Word address of the 32 bit software window
  localparam int unsigned SwAddrWidth      = 9;

  typedef logic [OtpAddrWidth-1:0] otp_addr_t;
  typedef logic [OtpSizeWidth-1:0] otp_size_t;
  typedef logic [SwAddrWidth-1:0]  sw_addr_t;
  typedef logic [BlockWidth-1:0]   block_t;
  typedef logic [1:0]              bus_err_t;

  ////////////////////////////////////////////////////
  // Partition geometry
  ////////////////////////////////////////////////////

  localparam logic [OtpByteAddrWidth-1:0] PartOffset = 11'd64;
  localparam logic [OtpByteAddrWidth-1:0] PartSize   = 11'd128;
  localparam logic [OtpByteAddrWidth-1:0] PartEnd    = PartOffset + PartSize;
  // Digest sits in the last 64 bit block
  localparam logic [OtpByteAddrWidth-1:0] DigestOffset =
      PartEnd - OtpByteAddrWidth'(BlockWidth / 8);

  // Read sizes for a data word and a full block
  localparam otp_size_t SizeData  = otp_size_t'(32 / OtpWidth - 1);
  localparam otp_size_t SizeBlock = otp_size_t'(BlockWidth / OtpWidth - 1);

  // Makes the bus adapter answer with an error
  localparam bus_err_t BusErr = 2'b11;

  ////////////////////////////////////////////////////
  // Codes
  ////////////////////////////////////////////////////

  // Shared with the macro, which reports in the same encoding
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    AccessError         = 3'h4,
    FsmStateError       = 3'h5
  } otp_err_e;

  // Source of the macro address
  typedef enum logic {
    DigestSel = 1'b0,
    DataSel   = 1'b1
  } addr_sel_e;

endpackage

`default_nettype wire

//--- src/otp_part_fsm.sv
/*
  Partition FSM with error register and bus response generation.
  One bus request outstanding at a time; ErrorSt is terminal until reset.
*/
`default_nettype none

module otp_part_fsm (
  input  wire                             clk_i,
  input  wire                             rst_ni,
  // Init and escalation
  input  wire                             init_req_i,
  input  wire                             escalate_en_i,
  // Bus request side
  input  wire                             tlul_req_i,
  input  wire                             addr_ok_i,
  input  wire                             read_lock_i,
  // Macro response side
  input  wire                             otp_gnt_i,
  input  wire                             otp_rvalid_i,
  input  otp_part_pkg::otp_err_e          otp_err_i,
  input  wire  [31:0]                     otp_rdata_i,
  // Status
  output logic                            init_done_o,
  output otp_part_pkg::otp_err_e          error_o,
  output logic                            fsm_err_o,
  // Bus response
  output logic                            tlul_gnt_o,
  output logic                            tlul_rvalid_o,
  output otp_part_pkg::bus_err_t          tlul_rerror_o,
  output logic [31:0]                     tlul_rdata_o,
  // Macro request and datapath control
  output logic                            otp_req_o,
  output otp_part_pkg::addr_sel_e         addr_sel_o,
  output logic                            digest_en_o
);

  typedef enum logic [2:0] {
    ResetSt,
    InitSt,
    InitWaitSt,
    IdleSt,
    ReadSt,
    ReadWaitSt,
    ErrorSt
  } state_e;

  state_e state_d, state_q;
  otp_part_pkg::otp_err_e error_d, error_q;
  // Granted request still owed a bus error in ErrorSt
  logic pending_err_d, pending_err_q;

  assign error_o = error_q;

  // No data goes out with an error or without a response
  assign tlul_rdata_o = (tlul_rvalid_o && tlul_rerror_o == '0) ? otp_rdata_i : '0;

  ////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d       = state_q;
    error_d       = error_q;
    pending_err_d = 1'b0;
    init_done_o   = 1'b0;
    otp_req_o     = 1'b0;
    addr_sel_o    = otp_part_pkg::DigestSel;
    digest_en_o   = 1'b0;
    tlul_gnt_o    = 1'b0;
    tlul_rvalid_o = 1'b0;
    tlul_rerror_o = '0;
    fsm_err_o     = 1'b0;

    unique case (state_q)
      // Wait for the init pulse
      ResetSt: begin
        if (init_req_i) begin
          state_d = InitSt;
        end
      end
      // Request the digest block
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      // Digest is loaded whatever the macro reports
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          digest_en_o = 1'b1;
          if (otp_err_i inside {otp_part_pkg::NoError, otp_part_pkg::MacroEccCorrError}) begin
            state_d = IdleSt;
            if (otp_err_i != otp_part_pkg::NoError) begin
              error_d = otp_part_pkg::MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err_i;
          end
        end
      end
      // Grant straight away; soft errors clear here
      IdleSt: begin
        init_done_o = 1'b1;
        if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          error_d    = otp_part_pkg::NoError;
          state_d    = ReadSt;
        end
      end
      // Window and lock check, then fetch
      ReadSt: begin
        init_done_o = 1'b1;
        if (addr_ok_i && !read_lock_i) begin
          otp_req_o  = 1'b1;
          addr_sel_o = otp_part_pkg::DataSel;
          if (otp_gnt_i) begin
            state_d = ReadWaitSt;
          end
        end else begin
          // Rejected read is not fatal
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = otp_part_pkg::BusErr;
          error_d       = otp_part_pkg::AccessError;
          state_d       = IdleSt;
        end
      end
      // Response goes out in the rvalid cycle
      ReadWaitSt: begin
        init_done_o = 1'b1;
        if (otp_rvalid_i) begin
          tlul_rvalid_o = 1'b1;
          if (otp_err_i inside {otp_part_pkg::NoError, otp_part_pkg::MacroEccCorrError}) begin
            state_d = IdleSt;
            if (otp_err_i != otp_part_pkg::NoError) begin
              error_d = otp_part_pkg::MacroEccCorrError;
            end
          end else begin
            tlul_rerror_o = otp_part_pkg::BusErr;
            error_d       = otp_err_i;
            state_d       = ErrorSt;
          end
        end
      end
      // Terminal; every request gets a bus error one cycle after its grant
      ErrorSt: begin
        if (pending_err_q) begin
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = otp_part_pkg::BusErr;
        end else if (tlul_req_i) begin
          tlul_gnt_o    = 1'b1;
          pending_err_d = 1'b1;
        end
      end
      default: begin
        state_d   = ErrorSt;
        error_d   = otp_part_pkg::FsmStateError;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_en_i) begin
      state_d   = ErrorSt;
      error_d   = otp_part_pkg::FsmStateError;
      fsm_err_o = 1'b1;
      // A read cut short still owes its response
      if ((state_q == ReadSt || state_q == ReadWaitSt) && !tlul_rvalid_o) begin
        pending_err_d = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q       <= ResetSt;
      error_q       <= otp_part_pkg::NoError;
      pending_err_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      error_q       <= error_d;
      pending_err_q <= pending_err_d;
    end
  end

endmodule

`default_nettype wire

//--- src/otp_part_addr.sv
/*
  Address unit. Holds the software word address of the granted request.
  Range check covers the whole partition including the digest block.
*/
`default_nettype none

module otp_part_addr (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire                     tlul_gnt_i,
  input  otp_part_pkg::sw_addr_t  tlul_addr_i,
  input  otp_part_pkg::addr_sel_e addr_sel_i,
  output logic                    addr_ok_o,
  output otp_part_pkg::otp_addr_t otp_addr_o,
  output otp_part_pkg::otp_size_t otp_size_o
);

  otp_part_pkg::sw_addr_t tlul_addr_q;
  // Byte addresses
  logic [otp_part_pkg::OtpByteAddrWidth-1:0] data_addr;
  logic [otp_part_pkg::OtpByteAddrWidth-1:0] addr_calc;

  ////////////////////////////////////////////////////
  // Request address
  ////////////////////////////////////////////////////

  // Latched on the grant, stable for the whole read
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_addr
    if (!rst_ni) begin
      tlul_addr_q <= '0;
    end else if (tlul_gnt_i) begin
      tlul_addr_q <= tlul_addr_i;
    end
  end

  // Word to byte address
  assign data_addr = {tlul_addr_q, 2'b00};

  // Lower bound inclusive, upper bound exclusive
  assign addr_ok_o = (data_addr >= otp_part_pkg::PartOffset) &&
                     (data_addr <  otp_part_pkg::PartEnd);

  ////////////////////////////////////////////////////
  // Macro address and size
  ////////////////////////////////////////////////////

  assign addr_calc = (addr_sel_i == otp_part_pkg::DigestSel) ? otp_part_pkg::DigestOffset :
                                                                data_addr;

  // Macro counts in halfwords
  assign otp_addr_o = addr_calc[otp_part_pkg::OtpByteAddrWidth-1:otp_part_pkg::OtpAddrShift];

  // Digest needs the full block, data one 32 bit word
  assign otp_size_o = (addr_sel_i == otp_part_pkg::DigestSel) ? otp_part_pkg::SizeBlock :
                                                                 otp_part_pkg::SizeData;

endmodule

`default_nettype wire

//--- src/otp_part_digest_lock.sv
/*
  Digest register and access-lock outputs.
  Locks are plain bits; both read as locked until init is done.
*/
`default_nettype none

module otp_part_digest_lock (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    digest_en_i,
  input  otp_part_pkg::block_t   otp_rdata_i,
  input  wire                    init_done_i,
  input  wire                    read_lock_i,
  input  wire                    write_lock_i,
  output otp_part_pkg::block_t   digest_o,
  output logic                   read_lock_o,
  output logic                   write_lock_o
);

  otp_part_pkg::block_t digest_q;
  // Lock causes shared by both outputs
  logic common_lock;

  ////////////////////////////////////////////////////
  // Digest
  ////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_digest
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (digest_en_i) begin
      digest_q <= otp_rdata_i;
    end
  end

  assign digest_o = digest_q;

  ////////////////////////////////////////////////////
  // Locks
  ////////////////////////////////////////////////////

  // Not initialised, or a digest has been written
  assign common_lock = !init_done_i || (digest_q != '0);

  // Locked out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_locks
    if (!rst_ni) begin
      read_lock_o  <= 1'b1;
      write_lock_o <= 1'b1;
    end else begin
      read_lock_o  <= read_lock_i || common_lock;
      write_lock_o <= write_lock_i || common_lock;
    end
  end

endmodule

`default_nettype wire

//--- src/otp_part_unbuf.sv
/*
  Unbuffered OTP partition controller top. Every macro read is an ECC read.
  Bus and macro ports use request/grant with a separate response valid.
*/
`default_nettype none

module otp_part_unbuf (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  // Control
  input  wire                            init_req_i,
  output logic                           init_done_o,
  input  wire                            escalate_en_i,
  output otp_part_pkg::otp_err_e         error_o,
  output logic                           fsm_err_o,
  // Access
  input  wire                            read_lock_i,
  input  wire                            write_lock_i,
  output logic                           read_lock_o,
  output logic                           write_lock_o,
  output otp_part_pkg::block_t           digest_o,
  // Bus port
  input  wire                            tlul_req_i,
  input  otp_part_pkg::sw_addr_t         tlul_addr_i,
  output logic                           tlul_gnt_o,
  output logic                           tlul_rvalid_o,
  output otp_part_pkg::bus_err_t         tlul_rerror_o,
  output logic [31:0]                    tlul_rdata_o,
  // Macro port
  output logic                           otp_req_o,
  output otp_part_pkg::otp_addr_t        otp_addr_o,
  output otp_part_pkg::otp_size_t        otp_size_o,
  input  wire                            otp_gnt_i,
  input  wire                            otp_rvalid_i,
  input  otp_part_pkg::block_t           otp_rdata_i,
  input  otp_part_pkg::otp_err_e         otp_err_i
);

  otp_part_pkg::addr_sel_e addr_sel;
  logic                    digest_en;
  logic                    addr_ok;

  // Control, error register and bus responses
  otp_part_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_req_i    (init_req_i),
    .escalate_en_i (escalate_en_i),
    .tlul_req_i    (tlul_req_i),
    .addr_ok_i     (addr_ok),
    // Registered lock feeds back into the read check
    .read_lock_i   (read_lock_o),
    .otp_gnt_i     (otp_gnt_i),
    .otp_rvalid_i  (otp_rvalid_i),
    .otp_err_i     (otp_err_i),
    .otp_rdata_i   (otp_rdata_i[31:0]),
    .init_done_o   (init_done_o),
    .error_o       (error_o),
    .fsm_err_o     (fsm_err_o),
    .tlul_gnt_o    (tlul_gnt_o),
    .tlul_rvalid_o (tlul_rvalid_o),
    .tlul_rerror_o (tlul_rerror_o),
    .tlul_rdata_o  (tlul_rdata_o),
    .otp_req_o     (otp_req_o),
    .addr_sel_o    (addr_sel),
    .digest_en_o   (digest_en)
  );

  // Address latch, window check, macro address
  otp_part_addr u_addr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tlul_gnt_i  (tlul_gnt_o),
    .tlul_addr_i (tlul_addr_i),
    .addr_sel_i  (addr_sel),
    .addr_ok_o   (addr_ok),
    .otp_addr_o  (otp_addr_o),
    .otp_size_o  (otp_size_o)
  );

  // Digest and published locks
  otp_part_digest_lock u_digest_lock (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .digest_en_i  (digest_en),
    .otp_rdata_i  (otp_rdata_i),
    .init_done_i  (init_done_o),
    .read_lock_i  (read_lock_i),
    .write_lock_i (write_lock_i),
    .digest_o     (digest_o),
    .read_lock_o  (read_lock_o),
    .write_lock_o (write_lock_o)
  );

endmodule

`default_nettype wire

//--- bench/otp_macro_model.sv
/*
  Behavioural OTP macro. Always returns 64 bits from the requested halfword on.
  The size field is ignored; the error code comes from the requested halfword only.
*/
`default_nettype none

module otp_macro_model (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  input  wire                     req_i,
  input  otp_part_pkg::otp_addr_t addr_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output otp_part_pkg::block_t    rdata_o,
  output otp_part_pkg::otp_err_e  err_o
);

  logic [15:0]            mem [1024];
  otp_part_pkg::otp_err_e err_mem [1024];
  otp_part_pkg::otp_addr_t addr_q;
  // Busy from grant until the response cycle
  logic                   busy_q;
  logic [1:0]             gnt_cnt_q;
  logic [1:0]             rsp_cnt_q;

  initial begin
    mem     = '{default: 16'h0000};
    err_mem = '{default: otp_part_pkg::NoError};
  end

  task automatic load_word(input otp_part_pkg::otp_addr_t addr, input logic [15:0] data);
    mem[addr] = data;
  endtask

  task automatic set_error(input otp_part_pkg::otp_addr_t addr,
                           input otp_part_pkg::otp_err_e err);
    err_mem[addr] = err;
  endtask

  // Grant with zero latency once the wait count has run out
  assign gnt_o    = req_i && !busy_q && (gnt_cnt_q == 2'd0);
  assign rvalid_o = busy_q && (rsp_cnt_q == 2'd0);
  // Four halfwords, lowest address in the low bits
  assign rdata_o  = {mem[addr_q + 10'd3], mem[addr_q + 10'd2],
                     mem[addr_q + 10'd1], mem[addr_q]};
  assign err_o    = rvalid_o ? err_mem[addr_q] : otp_part_pkg::NoError;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_delays
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      gnt_cnt_q <= 2'd0;
      rsp_cnt_q <= 2'd0;
      addr_q    <= '0;
    end else if (busy_q) begin
      if (rsp_cnt_q == 2'd0) begin
        busy_q    <= 1'b0;
        gnt_cnt_q <= 2'($urandom % 4);
      end else begin
        rsp_cnt_q <= rsp_cnt_q - 2'd1;
      end
    end else if (req_i) begin
      if (gnt_cnt_q == 2'd0) begin
        // Response 1 to 4 cycles after the grant
        busy_q    <= 1'b1;
        addr_q    <= addr_i;
        rsp_cnt_q <= 2'($urandom % 4);
      end else begin
        gnt_cnt_q <= gnt_cnt_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/otp_part_unbuf_tb.sv
/*
  Testbench for the unbuffered OTP partition controller.
  Runs from the project root; commands come from bench/otp_part_stim.txt.
*/
`default_nettype none

module otp_part_unbuf_tb;

  localparam int WdCyclesPerLine = 200;

  logic clk_i;
  logic rst_ni;
  logic init_req;
  logic init_done;
  logic escalate_en;
  logic fsm_err;
  logic rlock_in;
  logic wlock_in;
  logic rlock_out;
  logic wlock_out;
  logic tl_req;
  logic tl_gnt;
  logic tl_rvalid;
  logic otp_req;
  logic otp_gnt;
  logic otp_rvalid;
  logic [31:0] tl_rdata;
  otp_part_pkg::otp_err_e  part_err;
  otp_part_pkg::otp_err_e  otp_err;
  otp_part_pkg::block_t    digest;
  otp_part_pkg::block_t    otp_rdata;
  otp_part_pkg::sw_addr_t  tl_addr;
  otp_part_pkg::bus_err_t  tl_rerror;
  otp_part_pkg::otp_addr_t otp_addr;
  otp_part_pkg::otp_size_t otp_size;

  // Parsed stim lines
  byte         cmd_q[$];
  logic [63:0] arg0_q[$];
  logic [63:0] arg1_q[$];
  logic [63:0] arg2_q[$];
  logic [63:0] arg3_q[$];
  int          wd_cycles = 0;
  // Expected DUT state
  logic        ready;
  logic        terminal;
  logic [63:0] digest_exp;
  // Expected macro request of the access in progress
  otp_part_pkg::otp_addr_t exp_otp_addr;
  otp_part_pkg::otp_size_t exp_otp_size;

  otp_part_unbuf DUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .init_req_i (init_req), .init_done_o (init_done),
    .escalate_en_i (escalate_en), .error_o (part_err), .fsm_err_o (fsm_err),
    .read_lock_i (rlock_in), .write_lock_i (wlock_in),
    .read_lock_o (rlock_out), .write_lock_o (wlock_out), .digest_o (digest),
    .tlul_req_i (tl_req), .tlul_addr_i (tl_addr), .tlul_gnt_o (tl_gnt),
    .tlul_rvalid_o (tl_rvalid), .tlul_rerror_o (tl_rerror), .tlul_rdata_o (tl_rdata),
    .otp_req_o (otp_req), .otp_addr_o (otp_addr), .otp_size_o (otp_size),
    .otp_gnt_i (otp_gnt), .otp_rvalid_i (otp_rvalid),
    .otp_rdata_i (otp_rdata), .otp_err_i (otp_err)
  );

  otp_macro_model u_macro (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (otp_req), .addr_i (otp_addr),
    .gnt_o (otp_gnt), .rvalid_o (otp_rvalid), .rdata_o (otp_rdata), .err_o (otp_err)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic abort(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Run aborted");
  endtask

  // Locked unless initialised, not in error and digest still blank
  function automatic logic lock_expected(input logic lock_in);
    return lock_in || !ready || (digest_exp != '0);
  endfunction

  task automatic compare_locks();
    check("read_lock_o", 64'(rlock_out), 64'(lock_expected(rlock_in)));
    check("write_lock_o", 64'(wlock_out), 64'(lock_expected(wlock_in)));
  endtask

  // Macro address and size seen in every accepted macro request
  always @(negedge clk_i) begin : macro_req_monitor
    if (otp_req && otp_gnt) begin
      check("otp_addr_o", 64'(otp_addr), 64'(exp_otp_addr));
      check("otp_size_o", 64'(otp_size), 64'(exp_otp_size));
    end
  end

  task automatic load_stim();
    int          fd;
    string       line;
    logic [63:0] a0, a1, a2, a3;
    fd = $fopen("bench/otp_part_stim.txt", "r");
    if (fd == 0) begin
      abort("Cannot open the stimulus file bench/otp_part_stim.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comments and blank lines
        if (line.len() > 0 && line[0] != "#" && line[0] != "\n") begin
          a0 = '0;
          a1 = '0;
          a2 = '0;
          a3 = '0;
          void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a0, a1, a2, a3));
          cmd_q.push_back(line[0]);
          arg0_q.push_back(a0);
          arg1_q.push_back(a1);
          arg2_q.push_back(a2);
          arg3_q.push_back(a3);
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////

  task automatic reset_dut();
    @(posedge clk_i);
    #1;
    rst_ni      = 1'b0;
    init_req    = 1'b0;
    escalate_en = 1'b0;
    tl_req      = 1'b0;
    ready       = 1'b0;
    terminal    = 1'b0;
    digest_exp  = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // One cycle out of reset, still waiting for init
    @(posedge clk_i);
    @(negedge clk_i);
    check("init_done_o", 64'(init_done), 64'(0));
    check("error_o", 64'(part_err), 64'(otp_part_pkg::NoError));
    compare_locks();
  endtask

  task automatic init_partition(input logic [63:0] exp_digest);
    @(posedge clk_i);
    #1;
    // Digest is the last 8 bytes of the 64..191 byte window, read as four halfwords
    exp_otp_addr = otp_part_pkg::otp_addr_t'(184 / 2);
    exp_otp_size = 2'd3;
    init_req     = 1'b1;
    @(posedge clk_i);
    #1;
    init_req = 1'b0;
    @(negedge clk_i);
    while (!init_done) begin
      @(negedge clk_i);
    end
    ready      = 1'b1;
    digest_exp = exp_digest;
    check("digest_o", digest, exp_digest);
    check("error_o", 64'(part_err), 64'(otp_part_pkg::NoError));
    // Locks follow one cycle later
    @(negedge clk_i);
    compare_locks();
  endtask

  task automatic set_locks(input logic rl, input logic wl);
    @(posedge clk_i);
    #1;
    rlock_in = rl;
    wlock_in = wl;
    @(posedge clk_i);
    @(negedge clk_i);
    compare_locks();
  endtask

  task automatic read_word(input otp_part_pkg::sw_addr_t addr,
                           input otp_part_pkg::bus_err_t exp_rerror,
                           input logic [31:0] exp_rdata,
                           input otp_part_pkg::otp_err_e exp_err);
    int   lat;
    logic rsp_seen;
    @(posedge clk_i);
    #1;
    // A 32 bit word is two halfwords starting at word address times two
    exp_otp_addr = otp_part_pkg::otp_addr_t'(int'(addr) * 2);
    exp_otp_size = 2'd1;
    tl_req       = 1'b1;
    tl_addr      = addr;
    @(negedge clk_i);
    while (!tl_gnt) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    tl_req   = 1'b0;
    lat      = 0;
    rsp_seen = 1'b0;
    while (!rsp_seen) begin
      @(negedge clk_i);
      lat++;
      rsp_seen = tl_rvalid;
    end
    // Rejected reads and reads in the error state answer right away
    if (exp_err == otp_part_pkg::AccessError || terminal) begin
      check("tlul_rvalid_o latency", 64'(lat), 64'(1));
    end else begin
      // Fetched data leaves in the macro response cycle
      check("otp_rvalid_i with tlul_rvalid_o", 64'(otp_rvalid), 64'(1));
    end
    check("tlul_rerror_o", 64'(tl_rerror), 64'(exp_rerror));
    check("tlul_rdata_o", 64'(tl_rdata), 64'(exp_rdata));
    @(negedge clk_i);
    check("error_o", 64'(part_err), 64'(exp_err));
    if (!(exp_err inside {otp_part_pkg::NoError, otp_part_pkg::MacroEccCorrError,
                          otp_part_pkg::AccessError})) begin
      terminal = 1'b1;
      ready    = 1'b0;
    end
  endtask

  task automatic raise_escalation();
    @(posedge clk_i);
    #1;
    escalate_en = 1'b1;
    @(negedge clk_i);
    check("fsm_err_o", 64'(fsm_err), 64'(1));
    @(posedge clk_i);
    #1;
    escalate_en = 1'b0;
    @(negedge clk_i);
    check("fsm_err_o", 64'(fsm_err), 64'(0));
    check("error_o", 64'(part_err), 64'(otp_part_pkg::FsmStateError));
    terminal = 1'b1;
    ready    = 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////

  initial begin : main
    int   i;
    logic done;
    rst_ni      = 1'b0;
    init_req    = 1'b0;
    escalate_en = 1'b0;
    rlock_in    = 1'b0;
    wlock_in    = 1'b0;
    tl_req      = 1'b0;
    tl_addr     = '0;
    done        = 1'b0;
    void'($urandom(32'h2a47_3f66));
    load_stim();
    wd_cycles = cmd_q.size() * WdCyclesPerLine;
    reset_dut();
    for (i = 0; i < cmd_q.size() && !done; i++) begin
      case (cmd_q[i])
        "M": u_macro.load_word(otp_part_pkg::otp_addr_t'(arg0_q[i]), 16'(arg1_q[i]));
        "E": u_macro.set_error(otp_part_pkg::otp_addr_t'(arg0_q[i]),
                               otp_part_pkg::otp_err_e'(arg1_q[i][2:0]));
        "X": reset_dut();
        "I": init_partition(arg0_q[i]);
        "L": set_locks(arg0_q[i][0], arg1_q[i][0]);
        "R": read_word(otp_part_pkg::sw_addr_t'(arg0_q[i]),
                       otp_part_pkg::bus_err_t'(arg1_q[i]), 32'(arg2_q[i]),
                       otp_part_pkg::otp_err_e'(arg3_q[i][2:0]));
        "S": raise_escalation();
        "D": done = 1'b1;
        default: abort("Unknown command in the stimulus file");
      endcase
    end
    $display("Everything OK");
    $finish;
  end

  // Budget scales with the number of stim lines
  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk_i);
    abort($sformatf("Timeout, run did not finish within %0d cycles", wd_cycles));
  end

endmodule

`default_nettype wire

//--- otp_part_unbuf.f
src/otp_part_pkg.sv
src/otp_part_fsm.sv
src/otp_part_addr.sv
src/otp_part_digest_lock.sv
src/otp_part_unbuf.sv
bench/otp_macro_model.sv
bench/otp_part_unbuf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the OTP partition testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f otp_part_unbuf.f --top-module otp_part_unbuf_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Votp_part_unbuf_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Everything OK$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- bench/otp_part_stim.txt
# M hw_addr data | E hw_addr err | L rlock wlock | I digest | X reset | S escalate | D end
# R word_addr rerror rdata err (all fields hex)
M 020 1234
M 021 abcd
M 040 5a5a
M 041 0f0f
I 0000000000000000
L 0 0
R 010 0 abcd1234 0
R 00f 3 00000000 4
R 020 0 0f0f5a5a 0
R 030 3 00000000 4
L 1 0
R 010 3 00000000 4
L 0 1
R 020 0 0f0f5a5a 0
L 0 0
E 040 2
R 020 0 0f0f5a5a 2
R 010 0 abcd1234 0
E 020 3
R 010 3 00000000 3
R 020 3 00000000 3
E 020 0
X
I 0000000000000000
S
R 010 3 00000000 5
M 05c 00c3
M 05f 7e00
X
I 7e000000000000c3
L 0 0
R 010 3 00000000 4
D
